/* Bender.yml */
package:
  name: hps_io_bridge

sources:
  - rtl/hps_io_pkg.sv
  - rtl/io_frame_seq.sv
  - rtl/cmd_regs.sv
  - rtl/file_loader.sv
  - rtl/hps_io_bridge.sv
  - target: simulation
    files:
      - sim/tb_hps_io_bridge.sv

/* files.f */
rtl/hps_io_pkg.sv
rtl/io_frame_seq.sv
rtl/cmd_regs.sv
rtl/file_loader.sv
rtl/hps_io_bridge.sv
sim/tb_hps_io_bridge.sv

/* rtl/cmd_regs.sv */
`timescale 1ns/1ps

module cmd_regs
	import hps_io_pkg::*;
#(
	parameter int STRLEN = 1,
	// first character sits in the top byte
	parameter logic [8*STRLEN-1:0] CONF_STR = "A"
)
(
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       word_valid,
	input  cmd_t       cmd,
	input  word_idx_t  word_idx,
	input  host_word_t word,

	// readback toward the sequencer
	output host_word_t rdata,

	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output host_word_t joystick_0,
	output host_word_t joystick_1,
	output status_t    status
);

	cfg_t cfg_q;

	// other config bits are handled outside the core
	assign buttons = cfg_q[cfg_btn_lsb +: cfg_btn_w];
	assign forced_scandoubler = cfg_q[cfg_fsd_bit];

	//////////////////////////////////////////////////
	// register writes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_q <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
		end else if (word_valid) begin
			if (word_idx == word_idx_t'(1)) begin
				case (cmd)
					cmd_cfg: cfg_q <= word[cfg_w-1:0];
					cmd_joy0: joystick_0 <= word;
					cmd_joy1: joystick_1 <= word;
					// low half comes first
					cmd_status: status[15:0] <= word;
					default: ;
				endcase
			end else if (word_idx == word_idx_t'(2) && cmd == cmd_status) begin
				status[31:16] <= word;
			end
		end
	end

	//////////////////////////////////////////////////
	// config string readback

	// word n returns character n, past the end the host reads zero
	always_comb begin
		rdata = '0;
		if (cmd == cmd_conf_str && word_idx != '0 && int'(word_idx) <= STRLEN) begin
			rdata[7:0] = CONF_STR[8*(STRLEN - int'(word_idx)) +: 8];
		end
	end

	// an empty string leaves no valid part-select above
	if (STRLEN < 1) begin : g_strlen_chk
		$error("STRLEN must be at least 1");
	end

endmodule

/* rtl/file_loader.sv */
`timescale 1ns/1ps

module file_loader
	import hps_io_pkg::*;
#(
	// 1 selects 16-bit download words
	parameter int WIDE = 0,
	localparam int DATA_W = (WIDE != 0) ? 16 : 8
)
(
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              word_valid,
	input  cmd_t              cmd,
	input  word_idx_t         word_idx,
	input  host_word_t        word,

	output logic              ioctl_download,
	output logic [7:0]        ioctl_index,
	output logic              ioctl_wr,
	output ioctl_addr_t       ioctl_addr,
	output logic [DATA_W-1:0] ioctl_dout
);

	// byte address advances by the word size
	localparam ioctl_addr_t ADDR_STEP = (WIDE != 0) ? 2 : 1;

	ioctl_addr_t addr_q;
	logic        arg_valid;
	logic        data_word;

	// command word itself never carries data
	assign arg_valid = word_valid && (word_idx != '0);
	assign data_word = arg_valid && (cmd == cmd_file_tx_dat);

	//////////////////////////////////////////////////
	// download control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index <= '0;
			ioctl_wr <= 1'b0;
			addr_q <= '0;
		end else begin
			// one cycle pulse per data word
			ioctl_wr <= data_word;
			if (data_word) begin
				addr_q <= addr_q + ADDR_STEP;
			end
			if (arg_valid && cmd == cmd_file_index && word_idx == word_idx_t'(1)) begin
				ioctl_index <= word[7:0];
			end
			if (arg_valid && cmd == cmd_file_tx) begin
				// nonzero starts, zero ends
				ioctl_download <= (word[7:0] != '0);
				if (word[7:0] != '0) begin
					addr_q <= '0;
				end
			end
		end
	end

	// write payload, also final address at stop
	always_ff @(posedge clk_sys) begin
		if (data_word) begin
			ioctl_addr <= addr_q;
			ioctl_dout <= word[DATA_W-1:0];
		end else if (arg_valid && cmd == cmd_file_tx && word[7:0] == '0) begin
			ioctl_addr <= addr_q;
		end
	end

	// 16-bit words land on even byte addresses only
	a_wide_addr_even: assert property (@(posedge clk_sys) disable iff (reset)
		(WIDE != 0 && ioctl_wr) |-> !ioctl_addr[0])
		else $error("odd ioctl_addr on a 16-bit write");

endmodule

/* rtl/hps_io_bridge.sv */
`timescale 1ns/1ps

module hps_io_bridge
	import hps_io_pkg::*;
#(
	parameter int WIDE = 0,
	parameter int STRLEN = 4,
	parameter logic [8*STRLEN-1:0] CONF_STR = "AB;C",
	localparam int DATA_W = (WIDE != 0) ? 16 : 8
)
(
	input  logic              clk_sys,
	input  logic              reset,

	// host handshake
	input  logic              io_enable,
	input  logic              io_strobe,
	input  host_word_t        io_din,
	output host_word_t        io_dout,
	output logic              io_wait,

	// core configuration and inputs
	output logic [1:0]        buttons,
	output logic              forced_scandoubler,
	output host_word_t        joystick_0,
	output host_word_t        joystick_1,
	output status_t           status,

	// file download toward the core
	output logic              ioctl_download,
	output logic [7:0]        ioctl_index,
	output logic              ioctl_wr,
	output ioctl_addr_t       ioctl_addr,
	output logic [DATA_W-1:0] ioctl_dout,
	input  logic              ioctl_wait
);

	//////////////////////////////////////////////////
	// shared word stream

	logic       word_valid;
	cmd_t       cmd;
	word_idx_t  word_idx;
	host_word_t word;
	host_word_t rdata;

	io_frame_seq seq_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.io_wait    (io_wait),
		.rdata      (rdata),
		.ioctl_wait (ioctl_wait),
		.word_valid (word_valid),
		.cmd        (cmd),
		.word_idx   (word_idx),
		.word       (word)
	);

	//////////////////////////////////////////////////
	// decoders, side by side on the same words

	cmd_regs #(
		.STRLEN   (STRLEN),
		.CONF_STR (CONF_STR)
	) regs_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word_valid         (word_valid),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.word               (word),
		.rdata              (rdata),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	file_loader #(
		.WIDE (WIDE)
	) loader_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word_valid     (word_valid),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.word           (word),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* rtl/hps_io_pkg.sv */
package hps_io_pkg;

	//////////////////////////////////////////////////
	// field widths

	// one word on the host bus
	localparam int host_word_w = 16;
	// word position inside a frame, saturates at the top
	localparam int word_idx_w = 10;
	localparam int cmd_w = 8;
	localparam int ioctl_addr_w = 25;
	localparam int cfg_w = 8;
	localparam int status_w = 32;

	typedef logic [host_word_w-1:0] host_word_t;
	typedef logic [word_idx_w-1:0] word_idx_t;
	typedef logic [cmd_w-1:0] cmd_t;
	typedef logic [ioctl_addr_w-1:0] ioctl_addr_t;
	typedef logic [cfg_w-1:0] cfg_t;
	typedef logic [status_w-1:0] status_t;

	//////////////////////////////////////////////////
	// command codes, taken from word 0 of a frame

	// buttons and switches
	localparam cmd_t cmd_cfg = 8'h01;
	// digital joysticks
	localparam cmd_t cmd_joy0 = 8'h02;
	localparam cmd_t cmd_joy1 = 8'h03;

	// config string readback, one character per word
	localparam cmd_t cmd_conf_str = 8'h14;

	// status word, low half first
	localparam cmd_t cmd_status = 8'h1e;

	// file download
	localparam cmd_t cmd_file_tx = 8'h53;
	localparam cmd_t cmd_file_tx_dat = 8'h54;
	localparam cmd_t cmd_file_index = 8'h55;

	//////////////////////////////////////////////////
	// configuration byte layout

	// bits 1:0 are the buttons
	localparam int cfg_btn_lsb = 0;
	localparam int cfg_btn_w = 2;
	// bit 4 forces the scandoubler on
	localparam int cfg_fsd_bit = 4;

endpackage

/* rtl/io_frame_seq.sv */
`timescale 1ns/1ps

module io_frame_seq
	import hps_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,

	// host side
	input  logic       io_enable,
	input  logic       io_strobe,
	input  host_word_t io_din,
	output host_word_t io_dout,
	output logic       io_wait,

	// read data from the register decoder
	input  host_word_t rdata,
	// back-pressure from the download consumer
	input  logic       ioctl_wait,

	// word stream toward both decoders
	output logic       word_valid,
	output cmd_t       cmd,
	output word_idx_t  word_idx,
	output host_word_t word
);

	cmd_t      cmd_q;
	word_idx_t idx_q;

	//////////////////////////////////////////////////
	// word stream

	// a word is only taken inside a frame
	assign word_valid = io_enable & io_strobe;
	assign word = io_din;
	assign word_idx = idx_q;

	// the decoders see the command already while word 0 is on the bus
	assign cmd = (idx_q == '0) ? io_din[cmd_w-1:0] : cmd_q;

	// download side stalls the host directly
	assign io_wait = ioctl_wait;

	//////////////////////////////////////////////////
	// frame tracking

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_q <= '0;
			idx_q <= '0;
			io_dout <= '0;
		end else if (!io_enable) begin
			// frame closed, wait for the next command word
			cmd_q <= '0;
			idx_q <= '0;
			io_dout <= '0;
		end else if (io_strobe) begin
			if (idx_q == '0) begin
				cmd_q <= io_din[cmd_w-1:0];
			end
			// stop counting at the top, long frames keep the last index
			if (idx_q != '1) begin
				idx_q <= idx_q + 1'b1;
			end
			// read value for this word, held until the next strobe
			io_dout <= rdata;
		end
	end

	// host has to hold off while the consumer is stalled
	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		io_wait |-> !io_strobe)
		else $error("io_strobe seen while io_wait is high");

endmodule

/* sim/tb_hps_io_bridge.sv */
`timescale 1ns/1ps

module tb_hps_io_bridge
	import hps_io_pkg::*;
();

	localparam int n_ent = 9;
	localparam int max_words = 7;
	localparam int wait_limit = 50;
	localparam int stall_len = 4;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        io_enable;
	logic        io_strobe;
	host_word_t  io_din;
	host_word_t  io_dout;
	logic        io_wait;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	host_word_t  joystick_0;
	host_word_t  joystick_1;
	status_t     status;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ioctl_wait;

	hps_io_bridge #(
		.WIDE     (0),
		.STRLEN   (4),
		.CONF_STR ("AB;C")
	) dut_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wait         (ioctl_wait)
	);

	always #10 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// frame table and expected state after each frame

	host_word_t  t_word [n_ent][max_words];
	host_word_t  t_rd [n_ent][max_words];
	int          t_len [n_ent];
	// word index to stall before, 0 for none
	int          t_stall [n_ent];
	cfg_t        t_cfg [n_ent];
	host_word_t  t_joy0 [n_ent];
	host_word_t  t_joy1 [n_ent];
	status_t     t_status [n_ent];
	logic [7:0]  t_index [n_ent];
	logic        t_dl [n_ent];
	logic        t_addr_chk [n_ent];
	ioctl_addr_t t_addr [n_ent];
	int          t_nwr [n_ent];

	// running reference model while the table is filled
	cfg_t        m_cfg;
	host_word_t  m_joy0;
	host_word_t  m_joy1;
	status_t     m_status;
	logic [7:0]  m_index;
	logic        m_dl;
	ioctl_addr_t m_addr;
	int          m_nwr;
	int          ne;

	ioctl_addr_t exp_wr_addr [$];
	logic [7:0]  exp_wr_data [$];
	ioctl_addr_t got_wr_addr [$];
	logic [7:0]  got_wr_data [$];
	host_word_t  rd_got [max_words];
	logic        wr_prev;
	logic [31:0] lcg_state;
	string       conf_txt;

	function automatic host_word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	//////////////////////////////////////////////////
	// error reporting and compares

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input ioctl_addr_t got, input ioctl_addr_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// write monitor, samples the cycle that just ended
	always @(posedge clk_sys) begin
		if (reset) begin
			wr_prev <= 1'b0;
		end else begin
			wr_prev <= ioctl_wr;
			if (ioctl_wr) begin
				if (wr_prev)
					stop_with_error("ioctl_wr stayed high for more than one cycle");
				check_bit("ioctl_download", ioctl_download, 1'b1);
				got_wr_addr.push_back(ioctl_addr);
				got_wr_data.push_back(ioctl_dout);
			end
		end
	end

	//////////////////////////////////////////////////
	// table construction

	task automatic open_entry(input cmd_t c, input int nargs);
		t_len[ne] = nargs + 1;
		t_stall[ne] = 0;
		for (int k = 0; k < max_words; k++) begin
			t_word[ne][k] = '0;
			t_rd[ne][k] = '0;
		end
		t_word[ne][0] = host_word_t'(c);
	endtask

	task automatic close_entry(input logic addr_chk);
		t_cfg[ne] = m_cfg;
		t_joy0[ne] = m_joy0;
		t_joy1[ne] = m_joy1;
		t_status[ne] = m_status;
		t_index[ne] = m_index;
		t_dl[ne] = m_dl;
		t_addr_chk[ne] = addr_chk;
		t_addr[ne] = m_addr;
		t_nwr[ne] = m_nwr;
		ne++;
	endtask

	task automatic build_table();
		host_word_t v;
		host_word_t hi;
		ne = 0;
		m_cfg = '0;
		m_joy0 = '0;
		m_joy1 = '0;
		m_status = '0;
		m_index = '0;
		m_dl = 1'b0;
		m_addr = '0;
		m_nwr = 0;
		open_entry(cmd_cfg, 1);
		v = next_rand();
		t_word[ne][1] = v;
		m_cfg = v[7:0];
		close_entry(1'b0);
		open_entry(cmd_joy0, 1);
		v = next_rand();
		t_word[ne][1] = v;
		m_joy0 = v;
		close_entry(1'b0);
		open_entry(cmd_joy1, 1);
		v = next_rand();
		t_word[ne][1] = v;
		m_joy1 = v;
		close_entry(1'b0);
		// low half of status goes first
		open_entry(cmd_status, 2);
		v = next_rand();
		hi = next_rand();
		t_word[ne][1] = v;
		t_word[ne][2] = hi;
		m_status = {hi, v};
		close_entry(1'b0);
		// two words past the end of the string read zero
		open_entry(cmd_conf_str, 6);
		for (int k = 1; k <= 6; k++) begin
			if (k <= conf_txt.len())
				t_rd[ne][k] = host_word_t'(conf_txt[k-1]);
		end
		close_entry(1'b0);
		open_entry(cmd_file_index, 1);
		t_word[ne][1] = 16'h0007;
		m_index = 8'h07;
		close_entry(1'b0);
		open_entry(cmd_file_tx, 1);
		t_word[ne][1] = 16'h0001;
		m_dl = 1'b1;
		m_addr = '0;
		close_entry(1'b0);
		open_entry(cmd_file_tx_dat, 5);
		t_stall[ne] = 3;
		for (int k = 1; k <= 5; k++) begin
			v = next_rand();
			t_word[ne][k] = v;
			exp_wr_addr.push_back(m_addr);
			exp_wr_data.push_back(v[7:0]);
			m_addr++;
			m_nwr++;
		end
		close_entry(1'b0);
		open_entry(cmd_file_tx, 1);
		m_dl = 1'b0;
		close_entry(1'b1);
	endtask

	//////////////////////////////////////////////////
	// host driver

	// io_wait is sampled mid-cycle where it is stable
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (io_wait) begin
			n++;
			if (n > wait_limit)
				stop_with_error("timed out waiting for io_wait to fall");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#2;
	endtask

	task automatic hold_wait(input int n);
		ioctl_wait = 1'b1;
		repeat (n) begin
			@(negedge clk_sys);
			check_bit("io_wait", io_wait, 1'b1);
			@(posedge clk_sys);
			#2;
		end
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		check_bit("io_wait", io_wait, 1'b0);
		@(posedge clk_sys);
		#2;
	endtask

	task automatic send_frame(input int e);
		io_enable = 1'b1;
		for (int k = 0; k < t_len[e]; k++) begin
			// consumer stalls beside the host, which has to hold off on io_wait
			if (t_stall[e] != 0 && k == t_stall[e]) begin
				fork
					hold_wait(stall_len);
				join_none
			end
			wait_ready();
			io_strobe = 1'b1;
			io_din = t_word[e][k];
			@(posedge clk_sys);
			#2;
			io_strobe = 1'b0;
			rd_got[k] = io_dout;
		end
		io_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2;
	endtask

	task automatic check_entry(input int e);
		for (int k = 0; k < t_len[e]; k++)
			check_word("io_dout", rd_got[k], t_rd[e][k]);
		check_word("io_dout", io_dout, '0);
		check_word("buttons", host_word_t'(buttons), host_word_t'(t_cfg[e][1:0]));
		check_bit("forced_scandoubler", forced_scandoubler, t_cfg[e][4]);
		check_word("joystick_0", joystick_0, t_joy0[e]);
		check_word("joystick_1", joystick_1, t_joy1[e]);
		check_status("status", status, t_status[e]);
		check_word("ioctl_index", host_word_t'(ioctl_index), host_word_t'(t_index[e]));
		check_bit("ioctl_download", ioctl_download, t_dl[e]);
		if (t_addr_chk[e])
			check_addr("ioctl_addr", ioctl_addr, t_addr[e]);
		if (got_wr_addr.size() != t_nwr[e])
			stop_with_error($sformatf("expected %0d ioctl writes but saw %0d",
				t_nwr[e], got_wr_addr.size()));
		for (int k = 0; k < got_wr_addr.size(); k++) begin
			check_addr("ioctl_addr", got_wr_addr[k], exp_wr_addr[k]);
			check_word("ioctl_dout", host_word_t'(got_wr_data[k]), host_word_t'(exp_wr_data[k]));
		end
	endtask

	initial begin
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;
		lcg_state = 32'hea9ac2a3;
		conf_txt = "AB;C";
		build_table();
		repeat (3) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		// everything starts cleared
		check_bit("ioctl_wr", ioctl_wr, 1'b0);
		check_bit("ioctl_download", ioctl_download, 1'b0);
		check_word("io_dout", io_dout, '0);
		check_word("buttons", host_word_t'(buttons), '0);
		check_bit("forced_scandoubler", forced_scandoubler, 1'b0);
		check_word("joystick_0", joystick_0, '0);
		check_word("joystick_1", joystick_1, '0);
		check_status("status", status, '0);
		for (int e = 0; e < n_ent; e++) begin
			send_frame(e);
			check_entry(e);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule
